// ==== rtl/isa_pkg.sv ====
// isa definitions for the memory and writeback slice: load ops, address widths, csr map
package isa_pkg;

  // register file and csr addressing
  localparam int GPR_ADDR_WD = 5;
  localparam int CSR_ADDR_WD = 12;

  localparam int MEM_OP_WD = 3;

  // load ops, same coding as funct3 of the rv64 loads
  localparam logic [MEM_OP_WD-1:0] MEM_OP_LB  = 3'b000;
  localparam logic [MEM_OP_WD-1:0] MEM_OP_LH  = 3'b001;
  localparam logic [MEM_OP_WD-1:0] MEM_OP_LW  = 3'b010;
  localparam logic [MEM_OP_WD-1:0] MEM_OP_LD  = 3'b011;
  localparam logic [MEM_OP_WD-1:0] MEM_OP_LBU = 3'b100;
  localparam logic [MEM_OP_WD-1:0] MEM_OP_LHU = 3'b101;
  localparam logic [MEM_OP_WD-1:0] MEM_OP_LWU = 3'b110;

  // machine mode csrs held in the csr file
  localparam logic [CSR_ADDR_WD-1:0] CSR_MSTATUS = 12'h300;
  localparam logic [CSR_ADDR_WD-1:0] CSR_MTVEC   = 12'h305;
  localparam logic [CSR_ADDR_WD-1:0] CSR_MEPC    = 12'h341;
  localparam logic [CSR_ADDR_WD-1:0] CSR_MCAUSE  = 12'h342;

endpackage

// ==== rtl/pipe_pkg.sv ====
// pipeline definitions: stage field group sizes and default word and sram widths
package pipe_pkg;

  // default datapath sizes, overridden from the top level
  localparam int DEF_WORD_WD      = 64;
  localparam int DEF_SRAM_DATA_WD = 64;
  localparam int DEF_SRAM_AW      = 8;   // word address, 256 lines

  // execute to memory group
  // rd, csr, gpr_wen, csr_wen, mem_ren, mem_op, csr_inst_sel
  localparam int ES_TO_MS_CTRL_WD = isa_pkg::GPR_ADDR_WD + isa_pkg::CSR_ADDR_WD + 3
                                  + isa_pkg::MEM_OP_WD + 1;
  localparam int ES_TO_MS_DATA_NUM = 3;  // csrrdata, alu_result, csr_result

  // memory to writeback group
  // gpr_wen, rd, csr_wen, csr
  localparam int MS_TO_WS_CTRL_WD = 1 + isa_pkg::GPR_ADDR_WD + 1 + isa_pkg::CSR_ADDR_WD;
  localparam int MS_TO_WS_DATA_NUM = 2;  // gpr_result, csr_result

endpackage

// ==== rtl/lsu_load.sv ====
// load formatter, picks the addressed bytes out of an sram line and extends them
`timescale 1ns/10ps

module lsu_load #(
  parameter int WORD_WD      = pipe_pkg::DEF_WORD_WD,
  parameter int SRAM_DATA_WD = pipe_pkg::DEF_SRAM_DATA_WD
) (
  input  logic [2:0]                    i_raddr_align,     // low address bits
  input  logic [SRAM_DATA_WD-1:0]       i_data_sram_rdata,
  input  logic                          i_mem_ren,
  input  logic [isa_pkg::MEM_OP_WD-1:0] i_mem_op,
  output logic [WORD_WD-1:0]            o_rdata
);

  import isa_pkg::*;

  logic [SRAM_DATA_WD-1:0] line_shift;

  assign line_shift = i_data_sram_rdata >> {i_raddr_align, 3'b000};  // addressed byte to bit 0

  always_comb begin
    o_rdata = '0;
    if (i_mem_ren) begin
      case (i_mem_op)
        MEM_OP_LB:  o_rdata = {{(WORD_WD-8){line_shift[7]}}, line_shift[7:0]};
        MEM_OP_LH:  o_rdata = {{(WORD_WD-16){line_shift[15]}}, line_shift[15:0]};
        MEM_OP_LW:  o_rdata = {{(WORD_WD-32){line_shift[31]}}, line_shift[31:0]};
        MEM_OP_LD:  o_rdata = line_shift[WORD_WD-1:0];
        MEM_OP_LBU: o_rdata = {{(WORD_WD-8){1'b0}}, line_shift[7:0]};
        MEM_OP_LHU: o_rdata = {{(WORD_WD-16){1'b0}}, line_shift[15:0]};
        MEM_OP_LWU: o_rdata = {{(WORD_WD-32){1'b0}}, line_shift[31:0]};
        default:    o_rdata = '0;  // 3'b111 is no load
      endcase
    end
  end

  // no trap path here, so the execute side must only issue aligned accesses
  always_comb begin
    if (i_mem_ren) begin
      assert #0 (!((i_mem_op == MEM_OP_LH || i_mem_op == MEM_OP_LHU)
                   && i_raddr_align[0] != 1'b0))
        else $error("lsu_load: misaligned half load, offset %0d", i_raddr_align);
      assert #0 (!((i_mem_op == MEM_OP_LW || i_mem_op == MEM_OP_LWU)
                   && i_raddr_align[1:0] != 2'b00))
        else $error("lsu_load: misaligned word load, offset %0d", i_raddr_align);
    end
  end

endmodule

// ==== rtl/data_sram.sv ====
// data sram, synchronous read with a held output line and a separate fill write port
`timescale 1ns/10ps

module data_sram #(
  parameter int SRAM_DATA_WD = pipe_pkg::DEF_SRAM_DATA_WD,
  parameter int SRAM_AW      = pipe_pkg::DEF_SRAM_AW
) (
  input  logic                    i_clk,
  input  logic                    i_rst_n,
  // read port
  input  logic                    i_ren,
  input  logic [SRAM_AW-1:0]      i_raddr,
  // fill port
  input  logic                    i_wen,
  input  logic [SRAM_AW-1:0]      i_waddr,
  input  logic [SRAM_DATA_WD-1:0] i_wdata,
  output logic [SRAM_DATA_WD-1:0] o_rdata
);

  localparam int DEPTH = 1 << SRAM_AW;

  logic [SRAM_DATA_WD-1:0] mem [DEPTH];
  logic [SRAM_DATA_WD-1:0] rdata_q;

  always_ff @(posedge i_clk) begin
    if (i_wen) begin
      mem[i_waddr] <= i_wdata;
    end
  end

  // output line changes only on a read,
  // so a stalled load in the memory stage keeps its data
  always_ff @(posedge i_clk) begin
    if (i_ren) begin
      rdata_q <= mem[i_raddr];
    end
  end

  assign o_rdata = rdata_q;

  // fills and execute-side reads must not collide on one line
  assert property (@(posedge i_clk) disable iff (!i_rst_n)
    !(i_ren && i_wen && (i_raddr == i_waddr)))
    else $error("data_sram: read and fill hit line %0h together", i_raddr);

endmodule

// ==== rtl/mem_stage.sv ====
// memory stage that latches execute fields, formats load data and selects the register result
`timescale 1ns/10ps

module mem_stage #(
  parameter int WORD_WD      = pipe_pkg::DEF_WORD_WD,
  parameter int SRAM_DATA_WD = pipe_pkg::DEF_SRAM_DATA_WD
) (
  input  logic                            i_clk,
  input  logic                            i_rst_n,
  // allowin
  input  logic                            i_ws_allowin,
  output logic                            o_ms_allowin,
  // from execute
  input  logic                            i_es_valid,
  input  logic [isa_pkg::GPR_ADDR_WD-1:0] i_rd,
  input  logic [isa_pkg::CSR_ADDR_WD-1:0] i_csr,
  input  logic                            i_gpr_wen,
  input  logic                            i_csr_wen,
  input  logic                            i_mem_ren,
  input  logic [isa_pkg::MEM_OP_WD-1:0]   i_mem_op,
  input  logic                            i_csr_inst_sel,   // csr read value to rd
  input  logic [WORD_WD-1:0]              i_csrrdata,
  input  logic [WORD_WD-1:0]              i_alu_result,
  input  logic [WORD_WD-1:0]              i_csr_result,
  // to writeback
  output logic                            o_ms_to_ws_valid,
  output logic                            o_gpr_wen,
  output logic [isa_pkg::GPR_ADDR_WD-1:0] o_rd,
  output logic [WORD_WD-1:0]              o_gpr_result,
  output logic                            o_csr_wen,
  output logic [isa_pkg::CSR_ADDR_WD-1:0] o_csr,
  output logic [WORD_WD-1:0]              o_csr_result,
  // from data sram
  input  logic [SRAM_DATA_WD-1:0]         i_data_sram_rdata
);

  import isa_pkg::*;
  import pipe_pkg::*;

  logic                                       ms_valid;
  logic                                       es_fire;
  logic [ES_TO_MS_CTRL_WD-1:0]                ctrl_q;
  logic [ES_TO_MS_DATA_NUM-1:0][WORD_WD-1:0]  data_q;

  logic [GPR_ADDR_WD-1:0] ms_rd;
  logic [CSR_ADDR_WD-1:0] ms_csr;
  logic                   ms_gpr_wen;
  logic                   ms_csr_wen;
  logic                   ms_mem_ren;
  logic [MEM_OP_WD-1:0]   ms_mem_op;
  logic                   ms_csr_inst_sel;
  logic [WORD_WD-1:0]     ms_csrrdata;
  logic [WORD_WD-1:0]     ms_alu_result;
  logic [WORD_WD-1:0]     ms_csr_result;
  logic [WORD_WD-1:0]     load_rdata;

  assign o_ms_allowin     = !ms_valid || i_ws_allowin;
  assign o_ms_to_ws_valid = ms_valid;  // sram line is already there
  assign es_fire          = i_es_valid && o_ms_allowin;

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      ms_valid <= 1'b0;
    end else if (o_ms_allowin) begin
      ms_valid <= i_es_valid;
    end
  end

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      ctrl_q <= '0;
    end else if (es_fire) begin
      ctrl_q <= {i_rd, i_csr, i_gpr_wen, i_csr_wen, i_mem_ren, i_mem_op, i_csr_inst_sel};
    end
  end

  always_ff @(posedge i_clk) begin
    if (es_fire) begin
      data_q <= {i_csrrdata, i_alu_result, i_csr_result};
    end
  end

  assign {ms_rd, ms_csr, ms_gpr_wen, ms_csr_wen, ms_mem_ren, ms_mem_op, ms_csr_inst_sel} = ctrl_q;
  assign {ms_csrrdata, ms_alu_result, ms_csr_result} = data_q;

  lsu_load #(
    .WORD_WD           (WORD_WD),
    .SRAM_DATA_WD      (SRAM_DATA_WD)
  ) u_lsu_load (
    .i_raddr_align     (ms_alu_result[2:0]),  // alu result is the load address
    .i_data_sram_rdata (i_data_sram_rdata),
    .i_mem_ren         (ms_mem_ren),
    .i_mem_op          (ms_mem_op),
    .o_rdata           (load_rdata)
  );

  assign o_gpr_result = ms_mem_ren ? load_rdata
                      : (ms_csr_inst_sel ? ms_csrrdata : ms_alu_result);
  assign o_gpr_wen    = ms_gpr_wen;
  assign o_rd         = ms_rd;
  assign o_csr_wen    = ms_csr_wen;
  assign o_csr        = ms_csr;
  assign o_csr_result = ms_csr_result;

  // a held instruction keeps its fields and its load line from the sram
  assert property (@(posedge i_clk) disable iff (!i_rst_n)
    (ms_valid && !i_ws_allowin)
      |=> ($stable(ctrl_q) && $stable(data_q) && $stable(o_gpr_result)))
    else $error("mem_stage: held instruction changed");

endmodule

// ==== rtl/wb_stage.sv ====
// writeback stage that commits results to the general register file and the csr file
`timescale 1ns/10ps

module wb_stage #(
  parameter int WORD_WD = pipe_pkg::DEF_WORD_WD
) (
  input  logic                            i_clk,
  input  logic                            i_rst_n,
  input  logic                            i_wb_hold,         // debug halt
  input  logic                            i_ms_to_ws_valid,
  output logic                            o_ws_allowin,
  input  logic                            i_gpr_wen,
  input  logic [isa_pkg::GPR_ADDR_WD-1:0] i_rd,
  input  logic [WORD_WD-1:0]              i_gpr_result,
  input  logic                            i_csr_wen,
  input  logic [isa_pkg::CSR_ADDR_WD-1:0] i_csr,
  input  logic [WORD_WD-1:0]              i_csr_result,
  // read ports
  input  logic [isa_pkg::GPR_ADDR_WD-1:0] i_rs1_addr,
  output logic [WORD_WD-1:0]              o_rs1_data,
  input  logic [isa_pkg::CSR_ADDR_WD-1:0] i_csr_raddr,
  output logic [WORD_WD-1:0]              o_csr_rdata
);

  import isa_pkg::*;
  import pipe_pkg::*;

  localparam int GPR_NUM = 1 << GPR_ADDR_WD;

  logic                                       ws_valid;
  logic                                       ws_ready_go;
  logic                                       ms_fire;
  logic                                       ws_commit;
  logic [MS_TO_WS_CTRL_WD-1:0]                ctrl_q;
  logic [MS_TO_WS_DATA_NUM-1:0][WORD_WD-1:0]  data_q;
  logic                                       ws_gpr_wen;
  logic [GPR_ADDR_WD-1:0]                     ws_rd;
  logic                                       ws_csr_wen;
  logic [CSR_ADDR_WD-1:0]                     ws_csr;
  logic [WORD_WD-1:0]                         ws_gpr_result;
  logic [WORD_WD-1:0]                         ws_csr_result;
  logic [WORD_WD-1:0]                         gpr [GPR_NUM];
  logic [WORD_WD-1:0]                         csr_mstatus;
  logic [WORD_WD-1:0]                         csr_mtvec;
  logic [WORD_WD-1:0]                         csr_mepc;
  logic [WORD_WD-1:0]                         csr_mcause;

  assign ws_ready_go  = !i_wb_hold;
  assign o_ws_allowin = !ws_valid || ws_ready_go;  // last stage so nothing downstream
  assign ms_fire      = i_ms_to_ws_valid && o_ws_allowin;
  assign ws_commit    = ws_valid && ws_ready_go;

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      ws_valid <= 1'b0;
    end else if (o_ws_allowin) begin
      ws_valid <= i_ms_to_ws_valid;
    end
  end

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      ctrl_q <= '0;
    end else if (ms_fire) begin
      ctrl_q <= {i_gpr_wen, i_rd, i_csr_wen, i_csr};
    end
  end

  always_ff @(posedge i_clk) begin
    if (ms_fire) begin
      data_q <= {i_gpr_result, i_csr_result};
    end
  end

  assign {ws_gpr_wen, ws_rd, ws_csr_wen, ws_csr} = ctrl_q;
  assign {ws_gpr_result, ws_csr_result} = data_q;

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      for (int i = 0; i < GPR_NUM; i++) begin
        gpr[i] <= '0;
      end
    end else if (ws_commit && ws_gpr_wen && (ws_rd != '0)) begin  // x0 stays zero
      gpr[ws_rd] <= ws_gpr_result;
    end
  end

  assign o_rs1_data = gpr[i_rs1_addr];

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      csr_mstatus <= '0;
      csr_mtvec   <= '0;
      csr_mepc    <= '0;
      csr_mcause  <= '0;
    end else if (ws_commit && ws_csr_wen) begin
      case (ws_csr)
        CSR_MSTATUS: csr_mstatus <= ws_csr_result;
        CSR_MTVEC:   csr_mtvec   <= ws_csr_result;
        CSR_MEPC:    csr_mepc    <= ws_csr_result;
        CSR_MCAUSE:  csr_mcause  <= ws_csr_result;
        default:     ;  // write to an unmodelled csr is dropped
      endcase
    end
  end

  always_comb begin
    case (i_csr_raddr)
      CSR_MSTATUS: o_csr_rdata = csr_mstatus;
      CSR_MTVEC:   o_csr_rdata = csr_mtvec;
      CSR_MEPC:    o_csr_rdata = csr_mepc;
      CSR_MCAUSE:  o_csr_rdata = csr_mcause;
      default:     o_csr_rdata = '0;
    endcase
  end

endmodule

// ==== rtl/mem_wb_top.sv ====
// memory and writeback slice top: data sram, memory stage and writeback stage
`timescale 1ns/10ps

module mem_wb_top #(
  parameter int WORD_WD      = pipe_pkg::DEF_WORD_WD,
  parameter int SRAM_DATA_WD = pipe_pkg::DEF_SRAM_DATA_WD,
  parameter int SRAM_AW      = pipe_pkg::DEF_SRAM_AW
) (
  input  logic                            i_clk,
  input  logic                            i_rst_n,
  // execute side
  input  logic                            i_es_valid,
  output logic                            o_ms_allowin,
  input  logic [isa_pkg::GPR_ADDR_WD-1:0] i_rd,
  input  logic [isa_pkg::CSR_ADDR_WD-1:0] i_csr,
  input  logic                            i_gpr_wen,
  input  logic                            i_csr_wen,
  input  logic                            i_mem_ren,
  input  logic [isa_pkg::MEM_OP_WD-1:0]   i_mem_op,
  input  logic                            i_csr_inst_sel,
  input  logic [WORD_WD-1:0]              i_csrrdata,
  input  logic [WORD_WD-1:0]              i_alu_result,
  input  logic [WORD_WD-1:0]              i_csr_result,
  input  logic                            i_wb_hold,
  // sram fill
  input  logic                            i_fill_wen,
  input  logic [SRAM_AW-1:0]              i_fill_addr,
  input  logic [SRAM_DATA_WD-1:0]         i_fill_wdata,
  // register file reads
  input  logic [isa_pkg::GPR_ADDR_WD-1:0] i_rs1_addr,
  output logic [WORD_WD-1:0]              o_rs1_data,
  input  logic [isa_pkg::CSR_ADDR_WD-1:0] i_csr_raddr,
  output logic [WORD_WD-1:0]              o_csr_rdata
);

  logic                            sram_ren;
  logic [SRAM_AW-1:0]              sram_raddr;
  logic [SRAM_DATA_WD-1:0]         sram_rdata;
  logic                            ws_allowin;
  logic                            ms_to_ws_valid;
  logic                            ms_gpr_wen;
  logic [isa_pkg::GPR_ADDR_WD-1:0] ms_rd;
  logic [WORD_WD-1:0]              ms_gpr_result;
  logic                            ms_csr_wen;
  logic [isa_pkg::CSR_ADDR_WD-1:0] ms_csr;
  logic [WORD_WD-1:0]              ms_csr_result;

  // read issued on the transfer edge, line ready while the load sits in mem
  assign sram_ren   = i_es_valid && o_ms_allowin && i_mem_ren;
  assign sram_raddr = i_alu_result[SRAM_AW+2:3];  // doubleword line index

  data_sram #(.SRAM_DATA_WD(SRAM_DATA_WD), .SRAM_AW(SRAM_AW)) u_data_sram (
    .i_clk (i_clk), .i_rst_n (i_rst_n), .i_ren (sram_ren), .i_raddr (sram_raddr),
    .i_wen (i_fill_wen), .i_waddr (i_fill_addr), .i_wdata (i_fill_wdata),
    .o_rdata (sram_rdata)
  );

  mem_stage #(.WORD_WD(WORD_WD), .SRAM_DATA_WD(SRAM_DATA_WD)) u_mem_stage (
    .i_clk (i_clk), .i_rst_n (i_rst_n), .i_ws_allowin (ws_allowin),
    .o_ms_allowin (o_ms_allowin), .i_es_valid (i_es_valid), .i_rd (i_rd), .i_csr (i_csr),
    .i_gpr_wen (i_gpr_wen), .i_csr_wen (i_csr_wen), .i_mem_ren (i_mem_ren),
    .i_mem_op (i_mem_op), .i_csr_inst_sel (i_csr_inst_sel), .i_csrrdata (i_csrrdata),
    .i_alu_result (i_alu_result), .i_csr_result (i_csr_result),
    .o_ms_to_ws_valid (ms_to_ws_valid), .o_gpr_wen (ms_gpr_wen), .o_rd (ms_rd),
    .o_gpr_result (ms_gpr_result), .o_csr_wen (ms_csr_wen), .o_csr (ms_csr),
    .o_csr_result (ms_csr_result), .i_data_sram_rdata (sram_rdata)
  );

  wb_stage #(.WORD_WD(WORD_WD)) u_wb_stage (
    .i_clk (i_clk), .i_rst_n (i_rst_n), .i_wb_hold (i_wb_hold),
    .i_ms_to_ws_valid (ms_to_ws_valid), .o_ws_allowin (ws_allowin),
    .i_gpr_wen (ms_gpr_wen), .i_rd (ms_rd), .i_gpr_result (ms_gpr_result),
    .i_csr_wen (ms_csr_wen), .i_csr (ms_csr), .i_csr_result (ms_csr_result),
    .i_rs1_addr (i_rs1_addr), .o_rs1_data (o_rs1_data),
    .i_csr_raddr (i_csr_raddr), .o_csr_rdata (o_csr_rdata)
  );

endmodule

// ==== tb/tb_mem_wb.sv ====
// testbench for the memory and writeback slice with file vectors and load sweeps under random hold
`timescale 1ns/10ps

module tb_mem_wb;

  import isa_pkg::*;

  localparam int NCOL       = 8;   // kind op rd csr flags a b expected
  localparam int MAXV       = 32;
  localparam int CLK_PERIOD = 100;

  logic                   i_clk;
  logic                   i_rst_n;
  logic                   i_es_valid;
  logic                   o_ms_allowin;
  logic [GPR_ADDR_WD-1:0] i_rd;
  logic [CSR_ADDR_WD-1:0] i_csr;
  logic                   i_gpr_wen;
  logic                   i_csr_wen;
  logic                   i_mem_ren;
  logic [MEM_OP_WD-1:0]   i_mem_op;
  logic                   i_csr_inst_sel;
  logic [63:0]            i_csrrdata;
  logic [63:0]            i_alu_result;
  logic [63:0]            i_csr_result;
  logic                   i_wb_hold;
  logic                   i_fill_wen;
  logic [7:0]             i_fill_addr;
  logic [63:0]            i_fill_wdata;
  logic [GPR_ADDR_WD-1:0] i_rs1_addr;
  logic [63:0]            o_rs1_data;
  logic [CSR_ADDR_WD-1:0] i_csr_raddr;
  logic [63:0]            o_csr_rdata;

  logic [63:0] vec [NCOL*MAXV];
  logic [31:0] lcg_state;
  bit          hold_en;
  int          pass_cnt;
  int          fail_cnt;
  int          wd_cycles;
  logic [7:0]  fill_addrs [$];
  logic [63:0] fill_datas [$];

  mem_wb_top #(.WORD_WD(64), .SRAM_DATA_WD(64), .SRAM_AW(8)) i_dut (
    .i_clk (i_clk), .i_rst_n (i_rst_n), .i_es_valid (i_es_valid),
    .o_ms_allowin (o_ms_allowin), .i_rd (i_rd), .i_csr (i_csr), .i_gpr_wen (i_gpr_wen),
    .i_csr_wen (i_csr_wen), .i_mem_ren (i_mem_ren), .i_mem_op (i_mem_op),
    .i_csr_inst_sel (i_csr_inst_sel), .i_csrrdata (i_csrrdata),
    .i_alu_result (i_alu_result), .i_csr_result (i_csr_result), .i_wb_hold (i_wb_hold),
    .i_fill_wen (i_fill_wen), .i_fill_addr (i_fill_addr), .i_fill_wdata (i_fill_wdata),
    .i_rs1_addr (i_rs1_addr), .o_rs1_data (o_rs1_data),
    .i_csr_raddr (i_csr_raddr), .o_csr_rdata (o_csr_rdata)
  );

  initial begin
    i_clk = 1'b0;
    forever #(CLK_PERIOD/2) i_clk = ~i_clk;
  end

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // roughly one edge in four held
  initial begin
    forever begin
      @(posedge i_clk);
      if (hold_en) begin
        i_wb_hold <= (lcg_next() >> 30) == 32'd3;
      end else begin
        i_wb_hold <= 1'b0;
      end
    end
  end

  // byte n of the access is byte off+n of the line before extension
  function automatic logic [63:0] load_expect(input logic [63:0] line, input logic [2:0] op,
                                              input int off);
    int          nbytes;
    logic [63:0] v;
    nbytes = 1 << op[1:0];
    v = '0;
    for (int i = 0; i < nbytes; i++) v[8*i +: 8] = line[8*(off+i) +: 8];
    if (!op[2] && v[8*nbytes-1]) begin
      for (int i = nbytes; i < 8; i++) v[8*i +: 8] = 8'hff;
    end
    return v;
  endfunction

  task automatic show_pass(input string name);
    $display("ok   %s", name);
    pass_cnt++;
  endtask

  task automatic show_fail(input string name, input logic [63:0] exp, input logic [63:0] act);
    $display("Fail %s expected %h actual %h", name, exp, act);
    fail_cnt++;
  endtask

  task automatic wait_commit_edges(input int n);
    int cnt;
    cnt = 0;
    while (cnt < n) begin
      @(posedge i_clk);
      if (!i_wb_hold) cnt++;
    end
  endtask

  task automatic read_gpr(input logic [4:0] addr, output logic [63:0] data);
    @(posedge i_clk);
    i_rs1_addr <= addr;
    @(posedge i_clk);
    data = o_rs1_data;
  endtask

  task automatic read_csr(input logic [11:0] addr, output logic [63:0] data);
    @(posedge i_clk);
    i_csr_raddr <= addr;
    @(posedge i_clk);
    data = o_csr_rdata;
  endtask

  task automatic fill_line(input logic [7:0] addr, input logic [63:0] data);
    @(posedge i_clk);
    i_fill_wen   <= 1'b1;
    i_fill_addr  <= addr;
    i_fill_wdata <= data;
    @(posedge i_clk);
    i_fill_wen   <= 1'b0;
  endtask

  // fields go out with nba at the calling clock edge
  task automatic drive_fields(input logic [2:0] op, input logic [4:0] rd, input logic [11:0] csr,
                              input logic [2:0] flags, input logic ren,
                              input logic [63:0] a, input logic [63:0] b);
    i_es_valid     <= 1'b1;
    i_mem_op       <= op;
    i_rd           <= rd;
    i_csr          <= csr;
    i_gpr_wen      <= flags[0];
    i_csr_inst_sel <= flags[1];
    i_csr_wen      <= flags[2];
    i_mem_ren      <= ren;
    i_alu_result   <= a;
    i_csrrdata     <= b;
    i_csr_result   <= b;
  endtask

  task automatic issue_one(input logic [2:0] op, input logic [4:0] rd, input logic [11:0] csr,
                           input logic [2:0] flags, input logic ren,
                           input logic [63:0] a, input logic [63:0] b);
    @(posedge i_clk);
    drive_fields(op, rd, csr, flags, ren, a, b);
    do @(posedge i_clk); while (!(i_es_valid && o_ms_allowin));
    i_es_valid <= 1'b0;
    wait_commit_edges(3);
  endtask

  // all legal op and offset pairs of one line back to back with one rd each
  task automatic sweep_line(input logic [7:0] laddr, input logic [63:0] ldata);
    logic [2:0]  ops [$];
    int          offs [$];
    int          k;
    logic [63:0] act;
    logic [63:0] exp;
    string       name;
    for (int op = 0; op <= int'(MEM_OP_LWU); op++) begin
      for (int off = 0; off < 8; off += (1 << op[1:0])) begin
        ops.push_back(3'(op));
        offs.push_back(off);
      end
    end
    k = 0;
    @(posedge i_clk);
    drive_fields(ops[0], 5'd1, '0, 3'b001, 1'b1, {53'd0, laddr, 3'd0} + 64'(offs[0]), '0);
    while (k < ops.size()) begin
      @(posedge i_clk);
      if (i_wb_hold && i_dut.u_mem_stage.ms_valid && i_dut.u_wb_stage.ws_valid
          && o_ms_allowin) begin
        $display("allowin stayed high with both stages full and held at %0t", $time);
        fail_cnt++;
      end
      if (i_es_valid && o_ms_allowin) begin
        k++;
        if (k < ops.size()) begin
          drive_fields(ops[k], 5'(k+1), '0, 3'b001, 1'b1,
                       {53'd0, laddr, 3'd0} + 64'(offs[k]), '0);
        end else begin
          i_es_valid <= 1'b0;
        end
      end
    end
    wait_commit_edges(4);  // drain both stages
    for (int i = 0; i < ops.size(); i++) begin
      read_gpr(5'(i+1), act);
      exp  = load_expect(ldata, ops[i], offs[i]);
      name = $sformatf("sweep_l%0h_op%0d_off%0d", laddr, ops[i], offs[i]);
      if (act !== exp) show_fail(name, exp, act);
      else show_pass(name);
    end
  endtask

  initial begin
    int          nvec;
    int          b;
    int          rst_bad;
    logic [63:0] act;
    logic [63:0] exp;
    string       name;
    i_rst_n = 1'b0;
    {i_es_valid, i_gpr_wen, i_csr_wen, i_mem_ren, i_csr_inst_sel, i_wb_hold} = '0;
    {i_rd, i_csr, i_mem_op, i_csrrdata, i_alu_result, i_csr_result} = '0;
    {i_fill_wen, i_fill_addr, i_fill_wdata, i_rs1_addr, i_csr_raddr} = '0;
    lcg_state = 32'h94d2_e5fc;
    hold_en   = 1'b0;
    pass_cnt  = 0;
    fail_cnt  = 0;
    rst_bad   = 0;
    $readmemh("tb/mem_wb_testdata.txt", vec);
    nvec = 0;
    while (nvec < MAXV && vec[nvec*NCOL] != 64'd4) begin
      if (vec[nvec*NCOL] == 64'd0) begin
        fill_addrs.push_back(vec[nvec*NCOL+5][7:0]);
        fill_datas.push_back(vec[nvec*NCOL+6]);
      end
      nvec++;
    end
    wd_cycles = (nvec + 29 * fill_addrs.size() + 1) * 20;
    repeat (5) @(posedge i_clk);
    i_rst_n <= 1'b1;
    @(posedge i_clk);
    @(posedge i_clk);
    if (o_ms_allowin !== 1'b1) show_fail("reset_allowin", 64'd1, 64'(o_ms_allowin));
    else show_pass("reset_allowin");
    for (int r = 0; r < 32; r++) begin
      read_gpr(5'(r), act);
      if (act !== 64'd0) begin
        show_fail($sformatf("reset_x%0d", r), 64'd0, act);
        rst_bad++;
      end
    end
    if (rst_bad == 0) show_pass("reset_gpr");
    hold_en = 1'b1;
    for (int v = 0; v < nvec; v++) begin
      b    = v * NCOL;
      exp  = vec[b+7];
      name = $sformatf("vec%0d_kind%0d", v, vec[b]);
      case (vec[b])
        64'd0: fill_line(vec[b+5][7:0], vec[b+6]);
        64'd3: begin
          issue_one(vec[b+1][2:0], vec[b+2][4:0], vec[b+3][11:0], vec[b+4][2:0], 1'b0,
                    vec[b+5], vec[b+6]);
          read_csr(vec[b+3][11:0], act);
          if (act !== exp) show_fail(name, exp, act);
          else show_pass(name);
        end
        default: begin
          issue_one(vec[b+1][2:0], vec[b+2][4:0], vec[b+3][11:0], vec[b+4][2:0],
                    vec[b] == 64'd1, vec[b+5], vec[b+6]);
          read_gpr(vec[b+2][4:0], act);
          if (act !== exp) show_fail(name, exp, act);
          else show_pass(name);
        end
      endcase
    end
    for (int f = 0; f < fill_addrs.size(); f++) sweep_line(fill_addrs[f], fill_datas[f]);
    $display("tests passed %0d, failed %0d", pass_cnt, fail_cnt);
    if (fail_cnt == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

  initial begin
    wait (wd_cycles > 0);
    repeat (wd_cycles + 100) @(posedge i_clk);
    $display("timeout, the tests did not finish within %0d cycles", wd_cycles + 100);
    $display("Simulation finished: FAIL");
    $finish;
  end

endmodule

// ==== tb/mem_wb_testdata.txt ====
// columns: kind op rd csr flags a b expected (flags bit0 gpr_wen, bit1 csr_inst_sel, bit2 csr_wen)
// kind 0 fill line a with b, 1 load from byte address a, 2 alu or csr read to rd, 3 csr write b, 4 end
0 0 0 000 0 0000000000000000 f0e1d2c3b4a59687 0000000000000000
0 0 0 000 0 0000000000000001 0123456789abcdef 0000000000000000
0 0 0 000 0 0000000000000002 80ff7f0180007fff 0000000000000000
1 0 05 000 1 0000000000000001 0000000000000000 ffffffffffffff96
1 4 06 000 1 0000000000000006 0000000000000000 00000000000000e1
1 1 07 000 1 000000000000000a 0000000000000000 ffffffffffff89ab
1 5 08 000 1 000000000000000e 0000000000000000 0000000000000123
1 2 09 000 1 0000000000000004 0000000000000000 fffffffff0e1d2c3
1 6 0a 000 1 0000000000000004 0000000000000000 00000000f0e1d2c3
1 3 0b 000 1 0000000000000010 0000000000000000 80ff7f0180007fff
1 2 0c 000 1 0000000000000010 0000000000000000 ffffffff80007fff
2 0 0d 000 1 123456789abcdef0 0000000000005555 123456789abcdef0
2 0 0e 000 3 0000000000001111 cafef00d12345678 cafef00d12345678
2 0 0d 000 0 000000000000dead 0000000000000000 123456789abcdef0
2 0 00 000 1 000000000000ffff 0000000000000000 0000000000000000
3 0 00 300 4 0000000000000000 0000000000001888 0000000000001888
3 0 00 305 4 0000000000000000 0000000080000100 0000000080000100
3 0 00 341 4 0000000000000000 0000000080000abc 0000000080000abc
3 0 00 342 4 0000000000000000 800000000000000b 800000000000000b
3 0 00 7c0 4 0000000000000000 000000000000aaaa 0000000000000000
4 0 00 000 0 0000000000000000 0000000000000000 0000000000000000

// ==== vlog.f ====
rtl/isa_pkg.sv
rtl/pipe_pkg.sv
rtl/lsu_load.sv
rtl/data_sram.sv
rtl/mem_stage.sv
rtl/wb_stage.sv
rtl/mem_wb_top.sv
tb/tb_mem_wb.sv

// ==== Makefile ====
SIM = obj_dir/tb_mem_wb

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"

$(SIM): vlog.f rtl/*.sv tb/tb_mem_wb.sv
	verilator --binary --timing --assert -Wno-fatal -f vlog.f --top-module tb_mem_wb -o tb_mem_wb

test: $(SIM)
	./$(SIM) | tee /dev/stderr | grep -q "Simulation finished: PASS"

clean:
	rm -rf obj_dir
